//--- hdl/gb_cpu_common_pkg.sv
package gb_cpu_common_pkg;

    // flag bit positions in F
    localparam int FLAG_Z = 7;
    localparam int FLAG_N = 6;
    localparam int FLAG_H = 5;
    localparam int FLAG_C = 4;

    localparam logic [7:0]  PREFIX_CB = 8'hCB;
    localparam logic [15:0] RESET_SP  = 16'hFFFE;

    typedef enum logic [3:0] {
        NOP, ADD, ADC, SUB, SBC, AND, XOR, OR, CP, INC, DEC, DAA, CPL, SCF, CCF
    } alu_op_t;

    // operand field order as encoded in the opcode
    typedef enum logic [2:0] {B, C, D, E, H, L, HL_MEM, A} opcode_r8_t;

    typedef enum logic [1:0] {BC, DE, HL, SP} opcode_r16_t;

    typedef enum logic [2:0] {R16_NONE, R16_INC, R16_DEC, R16_ADD_HL, R16_ADD_SP} r16_op_t;

    typedef enum logic [2:0] {FETCH, DECODE, OPERAND, EXECUTE, RETIRE} ctrl_state_t;

    typedef struct packed {
        alu_op_t     alu_opcode;
        opcode_r8_t  r8;
        opcode_r16_t r16;
        r16_op_t     r16_op;
        // one operand byte follows the opcode
        logic        immediate_op;
        // operand comes from [hl]
        logic        mem_op;
        logic        write_result;
        // execute M-cycles
        logic [1:0]  m_cycles;
    } schedule_t;

    function automatic schedule_t arithmetic8Bit(
        alu_op_t    alu_opcode   = NOP,
        opcode_r8_t r8           = A,
        logic       immediate_op = 1'b0,
        logic       write_result = 1'b1
    );
        schedule_t s;
        s              = '0;
        s.alu_opcode   = alu_opcode;
        s.r8           = r8;
        s.immediate_op = immediate_op;
        s.mem_op       = (r8 == HL_MEM) && !immediate_op;
        s.write_result = write_result;
        s.m_cycles     = 2'd1;
        return s;
    endfunction

    function automatic schedule_t arithmetic16Bit(
        opcode_r16_t r16     = SP,
        logic        inc_dec = 1'b0,
        logic        add_hl  = 1'b0,
        logic        add_sp  = 1'b0
    );
        schedule_t s;
        s     = '0;
        s.r16 = r16;
        // add sp wins, then add hl, then inc/dec
        if (add_sp) begin
            s.r16_op       = R16_ADD_SP;
            s.immediate_op = 1'b1;
        end else if (add_hl) begin
            s.r16_op = R16_ADD_HL;
        end else begin
            s.r16_op = inc_dec ? R16_INC : R16_DEC;
        end
        s.m_cycles = 2'd2;
        return s;
    endfunction

    function automatic schedule_t emptySchedule();
        schedule_t s;
        s          = '0;
        s.m_cycles = 2'd1;
        return s;
    endfunction

endpackage : gb_cpu_common_pkg

//--- hdl/gb_cpu_decoder.sv
`timescale 1ns/1ns

module gb_cpu_decoder (
    input  logic [7:0]                   opcode,
    input  logic                         cb_prefix,
    output gb_cpu_common_pkg::schedule_t schedule
);

    import gb_cpu_common_pkg::*;

    opcode_r8_t  r8_hi;
    opcode_r8_t  r8_lo;
    opcode_r16_t pair;

    // operand fields of the opcode
    assign r8_hi = opcode_r8_t'(opcode[5:3]);
    assign r8_lo = opcode_r8_t'(opcode[2:0]);
    assign pair  = opcode_r16_t'(opcode[5:4]);

    always_comb begin : decode_logic
        schedule = emptySchedule();
        // prefixed opcodes all retire as no-ops
        if (!cb_prefix) begin
            case (opcode) inside
                // 16-bit pair ops
                8'b00_??_0011: schedule = arithmetic16Bit(.r16(pair), .inc_dec(1'b1));
                8'b00_??_1011: schedule = arithmetic16Bit(.r16(pair), .inc_dec(1'b0));
                8'b00_??_1001: schedule = arithmetic16Bit(.r16(pair), .add_hl(1'b1));
                // inc/dec r8, destination is the operand itself
                8'b00_???_100: schedule = arithmetic8Bit(.alu_opcode(INC), .r8(r8_hi));
                8'b00_???_101: schedule = arithmetic8Bit(.alu_opcode(DEC), .r8(r8_hi));
                // accumulator and flag ops
                8'b00_100111: schedule = arithmetic8Bit(.alu_opcode(DAA));
                8'b00_101111: schedule = arithmetic8Bit(.alu_opcode(CPL));
                8'b00_110111: schedule = arithmetic8Bit(.alu_opcode(SCF), .write_result(1'b0));
                8'b00_111111: schedule = arithmetic8Bit(.alu_opcode(CCF), .write_result(1'b0));
                // a op r8
                8'b10_000_???: schedule = arithmetic8Bit(.alu_opcode(ADD), .r8(r8_lo));
                8'b10_001_???: schedule = arithmetic8Bit(.alu_opcode(ADC), .r8(r8_lo));
                8'b10_010_???: schedule = arithmetic8Bit(.alu_opcode(SUB), .r8(r8_lo));
                8'b10_011_???: schedule = arithmetic8Bit(.alu_opcode(SBC), .r8(r8_lo));
                8'b10_100_???: schedule = arithmetic8Bit(.alu_opcode(AND), .r8(r8_lo));
                8'b10_101_???: schedule = arithmetic8Bit(.alu_opcode(XOR), .r8(r8_lo));
                8'b10_110_???: schedule = arithmetic8Bit(.alu_opcode(OR), .r8(r8_lo));
                8'b10_111_???: schedule = arithmetic8Bit(.alu_opcode(CP), .r8(r8_lo));
                // a op imm8
                8'b11_000_110: schedule = arithmetic8Bit(.alu_opcode(ADD), .immediate_op(1'b1));
                8'b11_001_110: schedule = arithmetic8Bit(.alu_opcode(ADC), .immediate_op(1'b1));
                8'b11_010_110: schedule = arithmetic8Bit(.alu_opcode(SUB), .immediate_op(1'b1));
                8'b11_011_110: schedule = arithmetic8Bit(.alu_opcode(SBC), .immediate_op(1'b1));
                8'b11_100_110: schedule = arithmetic8Bit(.alu_opcode(AND), .immediate_op(1'b1));
                8'b11_101_110: schedule = arithmetic8Bit(.alu_opcode(XOR), .immediate_op(1'b1));
                8'b11_110_110: schedule = arithmetic8Bit(.alu_opcode(OR), .immediate_op(1'b1));
                8'b11_111_110: schedule = arithmetic8Bit(.alu_opcode(CP), .immediate_op(1'b1));
                // add sp, signed imm8
                8'b11_101000: schedule = arithmetic16Bit(.add_sp(1'b1));
                default: schedule = emptySchedule();
            endcase
        end
    end : decode_logic

endmodule : gb_cpu_decoder

//--- hdl/gb_cpu_alu.sv
`timescale 1ns/1ns

module gb_cpu_alu (
    input  gb_cpu_common_pkg::alu_op_t alu_opcode,
    input  logic [7:0]                 alu_a,
    input  logic [7:0]                 alu_b,
    input  logic [7:0]                 alu_f_in,
    output logic [7:0]                 alu_result,
    output logic [7:0]                 alu_f_out
);

    import gb_cpu_common_pkg::*;

    logic       carry;
    logic [4:0] half;
    logic [8:0] full;
    logic [7:0] corr;
    logic       flag_z;
    logic       flag_n;
    logic       flag_h;
    logic       flag_c;

    // carry only feeds adc and sbc
    assign carry = alu_f_in[FLAG_C] & ((alu_opcode == ADC) | (alu_opcode == SBC));

    always_comb begin : alu_logic
        alu_result = alu_a;
        half       = '0;
        full       = '0;
        corr       = '0;
        flag_n     = alu_f_in[FLAG_N];
        flag_h     = alu_f_in[FLAG_H];
        flag_c     = alu_f_in[FLAG_C];
        case (alu_opcode)
            ADD, ADC: begin
                half       = {1'b0, alu_a[3:0]} + {1'b0, alu_b[3:0]} + {4'd0, carry};
                full       = {1'b0, alu_a} + {1'b0, alu_b} + {8'd0, carry};
                alu_result = full[7:0];
                flag_n     = 1'b0;
                flag_h     = half[4];
                flag_c     = full[8];
            end
            SUB, SBC, CP: begin
                // bit 4 / bit 8 catch the borrow
                half       = {1'b0, alu_a[3:0]} - {1'b0, alu_b[3:0]} - {4'd0, carry};
                full       = {1'b0, alu_a} - {1'b0, alu_b} - {8'd0, carry};
                alu_result = full[7:0];
                flag_n     = 1'b1;
                flag_h     = half[4];
                flag_c     = full[8];
            end
            AND, XOR, OR: begin
                if (alu_opcode == AND) begin
                    alu_result = alu_a & alu_b;
                end else if (alu_opcode == XOR) begin
                    alu_result = alu_a ^ alu_b;
                end else begin
                    alu_result = alu_a | alu_b;
                end
                flag_n = 1'b0;
                // and alone sets H
                flag_h = (alu_opcode == AND);
                flag_c = 1'b0;
            end
            INC, DEC: begin
                // C untouched here
                if (alu_opcode == INC) begin
                    half       = {1'b0, alu_b[3:0]} + 5'd1;
                    alu_result = alu_b + 8'd1;
                end else begin
                    half       = {1'b0, alu_b[3:0]} - 5'd1;
                    alu_result = alu_b - 8'd1;
                end
                flag_n = (alu_opcode == DEC);
                flag_h = half[4];
            end
            DAA: begin
                if (!alu_f_in[FLAG_N]) begin
                    // after add, correct each digit past 9
                    if (alu_f_in[FLAG_C] || alu_a > 8'h99) begin
                        corr[7:4] = 4'h6;
                        flag_c    = 1'b1;
                    end
                    if (alu_f_in[FLAG_H] || alu_a[3:0] > 4'h9) corr[3:0] = 4'h6;
                    alu_result = alu_a + corr;
                end else begin
                    // after sub, only the flags say what to undo
                    if (alu_f_in[FLAG_C]) corr[7:4] = 4'h6;
                    if (alu_f_in[FLAG_H]) corr[3:0] = 4'h6;
                    alu_result = alu_a - corr;
                end
                flag_h = 1'b0;
            end
            CPL: begin
                alu_result = ~alu_a;
                flag_n     = 1'b1;
                flag_h     = 1'b1;
            end
            SCF, CCF: begin
                flag_n = 1'b0;
                flag_h = 1'b0;
                flag_c = (alu_opcode == SCF) ? 1'b1 : ~alu_f_in[FLAG_C];
            end
            default: ;
        endcase
    end : alu_logic

    // Z kept for nop, cpl, scf and ccf
    assign flag_z = (alu_opcode inside {NOP, CPL, SCF, CCF}) ? alu_f_in[FLAG_Z]
                                                             : (alu_result == 8'h00);

    assign alu_f_out = {flag_z, flag_n, flag_h, flag_c, 4'h0};

endmodule : gb_cpu_alu

//--- hdl/gb_cpu_regfile.sv
`timescale 1ns/1ns

module gb_cpu_regfile (
    input  logic                             clk,
    input  logic                             arst_n,
    input  gb_cpu_common_pkg::opcode_r8_t    r8_sel,
    input  logic [7:0]                       r8_wdata,
    input  logic                             r8_we,
    input  logic [7:0]                       f_wdata,
    input  logic                             f_we,
    input  gb_cpu_common_pkg::opcode_r16_t   r16_sel,
    input  gb_cpu_common_pkg::r16_op_t       r16_op,
    input  logic                             r16_we,
    input  logic [7:0]                       imm8,
    output logic [7:0]                       rd_r8,
    output logic [7:0]                       reg_a,
    output logic [7:0]                       reg_f,
    output logic [15:0]                      reg_hl,
    output logic [7:0]                       r16_f
);

    import gb_cpu_common_pkg::*;

    logic [7:0]  reg_b, reg_c, reg_d, reg_e, reg_h, reg_l;
    logic [15:0] sp;
    logic [15:0] r16_val;
    logic [15:0] r16_next;
    logic [12:0] sum12;
    logic [8:0]  sum8;
    logic [4:0]  sum4;

    assign reg_hl = {reg_h, reg_l};

    // [hl] is not a register, reads back zero
    always_comb begin : r8_read
        case (r8_sel)
            B:       rd_r8 = reg_b;
            C:       rd_r8 = reg_c;
            D:       rd_r8 = reg_d;
            E:       rd_r8 = reg_e;
            H:       rd_r8 = reg_h;
            L:       rd_r8 = reg_l;
            A:       rd_r8 = reg_a;
            default: rd_r8 = 8'h00;
        endcase
    end : r8_read

    always_comb begin : r16_read
        case (r16_sel)
            BC:      r16_val = {reg_b, reg_c};
            DE:      r16_val = {reg_d, reg_e};
            HL:      r16_val = reg_hl;
            default: r16_val = sp;
        endcase
    end : r16_read

    // partial sums for the 16-bit flags
    assign sum12 = {1'b0, reg_hl[11:0]} + {1'b0, r16_val[11:0]};
    assign sum8  = {1'b0, sp[7:0]} + {1'b0, imm8};
    assign sum4  = {1'b0, sp[3:0]} + {1'b0, imm8[3:0]};

    always_comb begin : r16_alu
        r16_next = r16_val;
        r16_f    = reg_f;
        case (r16_op)
            R16_INC: r16_next = r16_val + 16'd1;
            R16_DEC: r16_next = r16_val - 16'd1;
            R16_ADD_HL: begin
                // carries from bit 11 and bit 15
                {r16_f[FLAG_C], r16_next} = {1'b0, reg_hl} + {1'b0, r16_val};
                r16_f[FLAG_N]             = 1'b0;
                r16_f[FLAG_H]             = sum12[12];
            end
            R16_ADD_SP: begin
                // sign-extended offset, flags from the low byte
                r16_next = sp + {{8{imm8[7]}}, imm8};
                r16_f    = {2'b00, sum4[4], sum8[8], 4'h0};
            end
            default: ;
        endcase
    end : r16_alu

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_b <= '0;
            reg_c <= '0;
            reg_d <= '0;
            reg_e <= '0;
            reg_h <= '0;
            reg_l <= '0;
            reg_a <= '0;
            reg_f <= '0;
            sp    <= RESET_SP;
        end else begin
            if (r8_we) begin
                case (r8_sel)
                    B: reg_b <= r8_wdata;
                    C: reg_c <= r8_wdata;
                    D: reg_d <= r8_wdata;
                    E: reg_e <= r8_wdata;
                    H: reg_h <= r8_wdata;
                    L: reg_l <= r8_wdata;
                    A: reg_a <= r8_wdata;
                    default: ;
                endcase
            end
            // low nibble of F reads as zero
            if (f_we) reg_f <= {f_wdata[7:4], 4'h0};
            if (r16_we) begin
                case (r16_sel)
                    BC:      {reg_b, reg_c} <= r16_next;
                    DE:      {reg_d, reg_e} <= r16_next;
                    HL:      {reg_h, reg_l} <= r16_next;
                    default: sp <= r16_next;
                endcase
            end
        end
    end

endmodule : gb_cpu_regfile

//--- hdl/gb_cpu_control.sv
`timescale 1ns/1ns

module gb_cpu_control (
    input  logic                           clk,
    input  logic                           arst_n,
    output logic [15:0]                    mem_addr,
    output logic                           mem_rd,
    input  logic [7:0]                     mem_rdata,
    output logic [7:0]                     opcode,
    output logic                           cb_prefix,
    input  gb_cpu_common_pkg::schedule_t   schedule,
    output gb_cpu_common_pkg::alu_op_t     alu_opcode,
    output logic [7:0]                     alu_a,
    output logic [7:0]                     alu_b,
    output logic [7:0]                     alu_f_in,
    input  logic [7:0]                     alu_result,
    input  logic [7:0]                     alu_f_out,
    output gb_cpu_common_pkg::opcode_r8_t  r8_sel,
    output logic [7:0]                     r8_wdata,
    output logic                           r8_we,
    output logic [7:0]                     f_wdata,
    output logic                           f_we,
    output gb_cpu_common_pkg::opcode_r16_t r16_sel,
    output gb_cpu_common_pkg::r16_op_t     r16_op,
    output logic                           r16_we,
    output logic [7:0]                     imm8,
    input  logic [15:0]                    reg_hl,
    input  logic [7:0]                     reg_a,
    input  logic [7:0]                     reg_f,
    input  logic [7:0]                     rd_r8,
    input  logic [7:0]                     r16_f,
    output logic                           retire_valid,
    output logic [15:0]                    retire_pc,
    output logic [7:0]                     retire_a,
    output logic [7:0]                     retire_f
);

    import gb_cpu_common_pkg::*;

    ctrl_state_t state;
    logic [15:0] pc;
    logic [15:0] start_pc;
    logic [7:0]  opcode_q;
    logic [7:0]  operand_q;
    logic        cb_q;
    logic [1:0]  cnt;
    logic        exec_last;
    logic        add16;
    logic        data_ready;

    // read data arrives on the second cycle of DECODE / OPERAND
    assign data_ready = (cnt == 2'd1);

    // decode straight from the bus while the byte is arriving
    assign opcode    = (state == DECODE && data_ready) ? mem_rdata : opcode_q;
    assign cb_prefix = cb_q;

    assign exec_last = (state == EXECUTE) && (cnt == schedule.m_cycles - 2'd1);
    assign add16     = schedule.r16_op inside {R16_ADD_HL, R16_ADD_SP};

    // ALU always works on A and the latched operand
    assign alu_opcode = schedule.alu_opcode;
    assign alu_a      = reg_a;
    assign alu_b      = operand_q;
    assign alu_f_in   = reg_f;

    // read port selects the operand, write port the destination
    always_comb begin : r8_select
        r8_sel = schedule.r8;
        if (state == EXECUTE && !(schedule.alu_opcode inside {INC, DEC})) r8_sel = A;
    end : r8_select

    assign r8_wdata = alu_result;
    // cp keeps only its flags
    assign r8_we    = exec_last && schedule.write_result && (schedule.alu_opcode != CP);
    assign f_wdata  = add16 ? r16_f : alu_f_out;
    assign f_we     = exec_last && ((schedule.alu_opcode != NOP) || add16);
    assign r16_sel  = schedule.r16;
    assign r16_op   = schedule.r16_op;
    assign r16_we   = exec_last && (schedule.r16_op != R16_NONE);
    assign imm8     = operand_q;

    // trace shows register state after the write
    assign retire_valid = (state == RETIRE);
    assign retire_pc    = start_pc;
    assign retire_a     = reg_a;
    assign retire_f     = reg_f;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= FETCH;
            pc        <= '0;
            start_pc  <= '0;
            opcode_q  <= '0;
            operand_q <= '0;
            cb_q      <= 1'b0;
            cnt       <= '0;
            mem_rd    <= 1'b0;
            mem_addr  <= '0;
        end else begin
            case (state)
                FETCH: begin
                    mem_rd   <= 1'b1;
                    mem_addr <= pc;
                    pc       <= pc + 16'd1;
                    // prefix byte keeps the first address
                    if (!cb_q) start_pc <= pc;
                    cnt      <= '0;
                    state    <= DECODE;
                end
                DECODE: begin
                    mem_rd <= 1'b0;
                    cnt    <= 2'd1;
                    if (data_ready) begin
                        opcode_q <= mem_rdata;
                        cnt      <= '0;
                        if (!cb_q && mem_rdata == PREFIX_CB) begin
                            // second opcode byte
                            cb_q  <= 1'b1;
                            state <= FETCH;
                        end else if (schedule.immediate_op || schedule.mem_op) begin
                            mem_rd   <= 1'b1;
                            mem_addr <= schedule.mem_op ? reg_hl : pc;
                            if (schedule.immediate_op) pc <= pc + 16'd1;
                            state    <= OPERAND;
                        end else begin
                            // register operand latched now
                            operand_q <= rd_r8;
                            state     <= EXECUTE;
                        end
                    end
                end
                OPERAND: begin
                    mem_rd <= 1'b0;
                    cnt    <= 2'd1;
                    if (data_ready) begin
                        operand_q <= mem_rdata;
                        cnt       <= '0;
                        state     <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    cnt <= cnt + 2'd1;
                    if (exec_last) state <= RETIRE;
                end
                RETIRE: begin
                    cb_q  <= 1'b0;
                    state <= FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

endmodule : gb_cpu_control

//--- hdl/gb_cpu_top.sv
`timescale 1ns/1ns

module gb_cpu_top (
    input  logic        clk,
    input  logic        arst_n,
    output logic [15:0] mem_addr,
    output logic        mem_rd,
    input  logic [7:0]  mem_rdata,
    output logic        retire_valid,
    output logic [15:0] retire_pc,
    output logic [7:0]  retire_a,
    output logic [7:0]  retire_f
);

    import gb_cpu_common_pkg::*;

    // control to decoder
    logic [7:0]  opcode;
    logic        cb_prefix;
    schedule_t   schedule;
    // ALU
    alu_op_t     alu_opcode;
    logic [7:0]  alu_a, alu_b, alu_f_in, alu_result, alu_f_out;
    // register file
    opcode_r8_t  r8_sel;
    logic [7:0]  r8_wdata, f_wdata, imm8, rd_r8, reg_a, reg_f, r16_f;
    logic        r8_we, f_we, r16_we;
    opcode_r16_t r16_sel;
    r16_op_t     r16_op;
    logic [15:0] reg_hl;

    gb_cpu_control control_i (
        .clk, .arst_n, .mem_addr, .mem_rd, .mem_rdata,
        .opcode, .cb_prefix, .schedule,
        .alu_opcode, .alu_a, .alu_b, .alu_f_in, .alu_result, .alu_f_out,
        .r8_sel, .r8_wdata, .r8_we, .f_wdata, .f_we,
        .r16_sel, .r16_op, .r16_we, .imm8,
        .reg_hl, .reg_a, .reg_f, .rd_r8, .r16_f,
        .retire_valid, .retire_pc, .retire_a, .retire_f
    );

    gb_cpu_decoder decoder_i (
        .opcode, .cb_prefix, .schedule
    );

    gb_cpu_alu alu_i (
        .alu_opcode, .alu_a, .alu_b, .alu_f_in, .alu_result, .alu_f_out
    );

    gb_cpu_regfile regfile_i (
        .clk, .arst_n,
        .r8_sel, .r8_wdata, .r8_we, .f_wdata, .f_we,
        .r16_sel, .r16_op, .r16_we, .imm8,
        .rd_r8, .reg_a, .reg_f, .reg_hl, .r16_f
    );

endmodule : gb_cpu_top

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk
);

    // 40 ns period
    localparam int HALF_PERIOD_NS = 20;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule : tb_clock_gen

//--- testbench/gb_cpu_tb.sv
`timescale 1ns/1ns

module gb_cpu_tb;

    // image holds the 64 KB memory, the trace region sits above it
    localparam int TRACE_BASE     = 32'h10000;
    localparam int MAX_RECORDS    = 64;
    localparam int RETIRE_TIMEOUT = 50;
    localparam int RESET_CYCLES   = 3;
    localparam string GOLDEN_FILE = "testbench/gb_cpu_golden.txt";

    logic        clk;
    logic        arst_n;
    logic [15:0] mem_addr;
    logic        mem_rd;
    logic [7:0]  mem_rdata = '0;
    logic        retire_valid;
    logic [15:0] retire_pc;
    logic [7:0]  retire_a;
    logic [7:0]  retire_f;

    logic [7:0] image [0:TRACE_BASE + 1 + 4 * MAX_RECORDS - 1];

    int num_records  = 0;
    int mismatches   = 0;
    int timeouts     = 0;
    int setup_errors = 0;

    tb_clock_gen clock_gen_i (
        .clk
    );

    gb_cpu_top dut_i (
        .clk,
        .arst_n,
        .mem_addr,
        .mem_rd,
        .mem_rdata,
        .retire_valid,
        .retire_pc,
        .retire_a,
        .retire_f
    );

    // read data one clock after mem_rd, no back-pressure
    always @(posedge clk) begin
        if (mem_rd) begin
            mem_rdata <= image[mem_addr];
        end
    end

    // outputs are sampled on the falling edge, half a cycle after they settle
    task automatic wait_for_retire(input int idx, output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = retire_valid;
        end
        if (!seen) begin
            $display("timeout at %0t: record %0d did not retire within %0d cycles",
                     $time, idx, RETIRE_TIMEOUT);
            timeouts++;
        end
    endtask

    // record layout is pc_hi, pc_lo, a, f
    task automatic check_record(input int idx);
        int          base;
        logic [15:0] exp_pc;
        logic [7:0]  exp_a;
        logic [7:0]  exp_f;
        base   = TRACE_BASE + 1 + 4 * idx;
        exp_pc = {image[base], image[base + 1]};
        exp_a  = image[base + 2];
        exp_f  = image[base + 3];
        assert (retire_pc == exp_pc) else begin
            $display("FAILED %0t: record %0d retire_pc %h, expected %h",
                     $time, idx, retire_pc, exp_pc);
            mismatches++;
        end
        assert (retire_a == exp_a) else begin
            $display("FAILED %0t: record %0d (pc %h) retire_a %h, expected %h",
                     $time, idx, exp_pc, retire_a, exp_a);
            mismatches++;
        end
        assert (retire_f == exp_f) else begin
            $display("FAILED %0t: record %0d (pc %h) retire_f %h, expected %h",
                     $time, idx, exp_pc, retire_f, exp_f);
            mismatches++;
        end
    endtask

    initial begin : run_test
        bit seen;
        arst_n = 1'b0;
        $readmemh(GOLDEN_FILE, image);
        // first byte of the trace region is the record count
        num_records = int'(image[TRACE_BASE]);
        if (num_records == 0 || num_records > MAX_RECORDS) begin
            $display("golden file gives %0d trace records, expected 1 to %0d",
                     num_records, MAX_RECORDS);
            setup_errors++;
            num_records = 0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        // one retire per record, in program order
        for (int i = 0; i < num_records; i++) begin
            wait_for_retire(i, seen);
            if (!seen) begin
                break;
            end
            check_record(i);
        end

        $display("mismatches %0d, timeouts %0d, golden file errors %0d",
                 mismatches, timeouts, setup_errors);
        if (mismatches == 0 && timeouts == 0 && setup_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end : run_test

endmodule : gb_cpu_tb

//--- testbench/gb_cpu_golden.txt
// program bytes from address 0000, a few instructions per line
// trace from 10000 is a record count, then pc_hi pc_lo a f per retire
@0000
c6 f8 ce 3a ce 0d d6 41       // add, adc, adc, sub. 3a at address 3 is the [hl] byte
de 0e e6 3c ee 30 f6 5a fe 6b // sbc, and, xor, or, cp
04 05 05 80                   // inc b, dec b, dec b, add a b
23 23 23 86                   // inc hl three times then add a [hl]
29 e8 ff                      // add hl hl then add sp ff
c6 28 27 2f 3f 37             // bcd add then daa, cpl, ccf, scf
41 cb 37 00 c6 01             // unsupported, cb pair, nop, add
@10000
1c
00 00 f8 00
00 02 32 30
00 04 40 20
00 06 ff 70
00 08 f0 40
00 0a 30 20
00 0c 00 80
00 0e 5a 00
00 10 5a 70
// inc and dec keep C
00 12 5a 10
00 13 5a d0
00 14 5a 70
00 15 59 30
00 16 59 30
00 17 59 30
00 18 59 30
00 19 93 20
// 16-bit flag rules
00 1a 93 00
00 1b 93 30
00 1d bb 00
00 1f 21 10
00 20 de 70
00 21 de 00
00 22 de 10
// no-ops, the cb pair takes two bytes
00 23 de 10
00 24 de 10
00 26 de 10
00 27 df 00

//--- tb.f
hdl/gb_cpu_common_pkg.sv
hdl/gb_cpu_decoder.sv
hdl/gb_cpu_alu.sv
hdl/gb_cpu_regfile.sv
hdl/gb_cpu_control.sv
hdl/gb_cpu_top.sv
testbench/tb_clock_gen.sv
testbench/gb_cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= gb_cpu_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ns
PASS_LINE ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fxq "$(PASS_LINE)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
